// ==== design/dispatch_pkg.sv ====
// Dispatch stage package with shared widths, vector types and the recovery state encoding
package dispatch_pkg;

	// ========================================
	// Pipeline widths
	// ========================================

	// Renamed instructions accepted from decode per cycle
	localparam int unsigned DECODE_WIDTH = 2;

	// Instructions handed to issue per cycle
	localparam int unsigned DISPATCH_WIDTH = 2;

	// Writeback ports driving wakeup
	localparam int unsigned WB_WIDTH = 2;

	// ========================================
	// Physical register file
	// ========================================

	localparam int unsigned PREG_NUM = 32;

	// Index width, log2 of PREG_NUM
	localparam int unsigned PREG_W = 5;

	// Opcode is carried through untouched
	localparam int unsigned OPCODE_W = 8;

	// ========================================
	// Types
	// ========================================

	typedef logic [PREG_W-1:0] preg_idx_t;

	typedef logic [OPCODE_W-1:0] opcode_t;

	// Flush recovery sequence
	// RUN normal dispatch, SWEEP walks ready table, RESUME one settle cycle
	typedef enum logic [1:0] {
		RUN    = 2'd0,
		SWEEP  = 2'd1,
		RESUME = 2'd2
	} rec_state_t;

endpackage

// ==== design/dispatch_queue.sv ====
// Circular dispatch queue, two in and two out per cycle, with writeback wakeup of sources
module dispatch_queue #(
	// Must be a power of two, pointers wrap naturally
	parameter int unsigned QUEUE_DEPTH = 8
) (
	input  logic                                                   clk,
	input  logic                                                   rst_n,
	input  logic                                                   flush_i,
	// Decode side
	input  logic [dispatch_pkg::DECODE_WIDTH-1:0]                  wr_valid_i,
	input  dispatch_pkg::opcode_t   [dispatch_pkg::DECODE_WIDTH-1:0] wr_opcode_i,
	input  dispatch_pkg::preg_idx_t [dispatch_pkg::DECODE_WIDTH-1:0] wr_pdest_i,
	input  dispatch_pkg::preg_idx_t [dispatch_pkg::DECODE_WIDTH-1:0] wr_src0_i,
	input  dispatch_pkg::preg_idx_t [dispatch_pkg::DECODE_WIDTH-1:0] wr_src1_i,
	input  logic [dispatch_pkg::DECODE_WIDTH-1:0]                  wr_src0_rdy_i,
	input  logic [dispatch_pkg::DECODE_WIDTH-1:0]                  wr_src1_rdy_i,
	input  logic                                                   write_block_i,
	output logic                                                   wr_ready_o,
	// Issue side
	output logic [dispatch_pkg::DISPATCH_WIDTH-1:0]                rd_valid_o,
	output dispatch_pkg::opcode_t   [dispatch_pkg::DISPATCH_WIDTH-1:0] rd_opcode_o,
	output dispatch_pkg::preg_idx_t [dispatch_pkg::DISPATCH_WIDTH-1:0] rd_pdest_o,
	output dispatch_pkg::preg_idx_t [dispatch_pkg::DISPATCH_WIDTH-1:0] rd_src0_o,
	output dispatch_pkg::preg_idx_t [dispatch_pkg::DISPATCH_WIDTH-1:0] rd_src1_o,
	output logic [dispatch_pkg::DISPATCH_WIDTH-1:0]                rd_src0_rdy_o,
	output logic [dispatch_pkg::DISPATCH_WIDTH-1:0]                rd_src1_rdy_o,
	input  logic [dispatch_pkg::DISPATCH_WIDTH-1:0]                rd_ready_i,
	// Wakeup
	input  logic [dispatch_pkg::WB_WIDTH-1:0]                      wb_valid_i,
	input  dispatch_pkg::preg_idx_t [dispatch_pkg::WB_WIDTH-1:0]   wb_pdest_i
);

	localparam int unsigned PTR_W = $clog2(QUEUE_DEPTH);
	localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);

	// Entry storage
	dispatch_pkg::opcode_t   ent_opcode   [QUEUE_DEPTH];
	dispatch_pkg::preg_idx_t ent_pdest    [QUEUE_DEPTH];
	dispatch_pkg::preg_idx_t ent_src0     [QUEUE_DEPTH];
	dispatch_pkg::preg_idx_t ent_src1     [QUEUE_DEPTH];
	logic                    ent_src0_rdy [QUEUE_DEPTH];
	logic                    ent_src1_rdy [QUEUE_DEPTH];

	logic [PTR_W-1:0] head_q;
	logic [PTR_W-1:0] tail_q;
	logic [CNT_W-1:0] cnt_q;

	logic [dispatch_pkg::DECODE_WIDTH-1:0] wr_fire;
	logic [dispatch_pkg::DISPATCH_WIDTH-1:0] rd_fire;
	logic [CNT_W-1:0] wr_cnt;
	logic [CNT_W-1:0] rd_cnt;
	logic [PTR_W-1:0] wr_idx [dispatch_pkg::DECODE_WIDTH];
	logic [PTR_W-1:0] rd_idx [dispatch_pkg::DISPATCH_WIDTH];

	// ========================================
	// Write side
	// ========================================

	// Room for a whole group, blocked during sweep
	assign wr_ready_o = (cnt_q <= CNT_W'(QUEUE_DEPTH - dispatch_pkg::DECODE_WIDTH))
		&& !write_block_i;
	assign wr_fire = wr_valid_i & {dispatch_pkg::DECODE_WIDTH{wr_ready_o}};
	assign wr_cnt  = CNT_W'($countones(wr_fire));

	for (genvar i = 0; i < dispatch_pkg::DECODE_WIDTH; i++) begin : gen_wr_idx
		// Slots are packed, so slot i lands at tail plus i
		assign wr_idx[i] = tail_q + PTR_W'(i);
	end

	// ========================================
	// Read side
	// ========================================

	for (genvar i = 0; i < dispatch_pkg::DISPATCH_WIDTH; i++) begin : gen_rd
		assign rd_idx[i]        = head_q + PTR_W'(i);
		assign rd_valid_o[i]    = cnt_q > CNT_W'(i);
		assign rd_opcode_o[i]   = ent_opcode[rd_idx[i]];
		assign rd_pdest_o[i]    = ent_pdest[rd_idx[i]];
		assign rd_src0_o[i]     = ent_src0[rd_idx[i]];
		assign rd_src1_o[i]     = ent_src1[rd_idx[i]];
		assign rd_src0_rdy_o[i] = ent_src0_rdy[rd_idx[i]];
		assign rd_src1_rdy_o[i] = ent_src1_rdy[rd_idx[i]];
	end

	assign rd_fire = rd_valid_o & rd_ready_i;
	assign rd_cnt  = CNT_W'($countones(rd_fire));

	// ========================================
	// Entry update
	// ========================================

	always_ff @(posedge clk) begin
		// Wakeup first over every stored entry
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			for (int j = 0; j < dispatch_pkg::WB_WIDTH; j++) begin
				if (wb_valid_i[j] && (ent_src0[i] == wb_pdest_i[j])) begin
					ent_src0_rdy[i] <= 1'b1;
				end
				if (wb_valid_i[j] && (ent_src1[i] == wb_pdest_i[j])) begin
					ent_src1_rdy[i] <= 1'b1;
				end
			end
		end
		// New entries override, their bits already carry the bypass
		for (int i = 0; i < dispatch_pkg::DECODE_WIDTH; i++) begin
			if (wr_fire[i]) begin
				ent_opcode[wr_idx[i]]   <= wr_opcode_i[i];
				ent_pdest[wr_idx[i]]    <= wr_pdest_i[i];
				ent_src0[wr_idx[i]]     <= wr_src0_i[i];
				ent_src1[wr_idx[i]]     <= wr_src1_i[i];
				ent_src0_rdy[wr_idx[i]] <= wr_src0_rdy_i[i];
				ent_src1_rdy[wr_idx[i]] <= wr_src1_rdy_i[i];
			end
		end
	end

	// Pointers and occupancy
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head_q <= '0;
			tail_q <= '0;
			cnt_q  <= '0;
		end else if (flush_i) begin
			// Flush drops everything, same-cycle writes included
			head_q <= '0;
			tail_q <= '0;
			cnt_q  <= '0;
		end else begin
			head_q <= head_q + PTR_W'(rd_cnt);
			tail_q <= tail_q + PTR_W'(wr_cnt);
			cnt_q  <= cnt_q + wr_cnt - rd_cnt;
		end
	end

	// ========================================
	// Checks
	// ========================================

	a_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
		cnt_q <= CNT_W'(QUEUE_DEPTH));

	// Issue consumes in order, a taken upper slot needs slot 0 taken too
	a_rd_in_order: assert property (@(posedge clk) disable iff (!rst_n)
		rd_fire[1] |-> rd_fire[0]);

endmodule

// ==== design/preg_ready_table.sv ====
// Physical register ready table with bypassed lookup, allocation clear and sweep set
module preg_ready_table (
	input  logic                                                     clk,
	input  logic                                                     rst_n,
	// Lookup per decode slot
	input  dispatch_pkg::preg_idx_t [dispatch_pkg::DECODE_WIDTH-1:0] lk_src0_i,
	input  dispatch_pkg::preg_idx_t [dispatch_pkg::DECODE_WIDTH-1:0] lk_src1_i,
	output logic [dispatch_pkg::DECODE_WIDTH-1:0]                    lk_src0_rdy_o,
	output logic [dispatch_pkg::DECODE_WIDTH-1:0]                    lk_src1_rdy_o,
	// Accepted destinations
	input  logic [dispatch_pkg::DECODE_WIDTH-1:0]                    alloc_valid_i,
	input  dispatch_pkg::preg_idx_t [dispatch_pkg::DECODE_WIDTH-1:0] alloc_pdest_i,
	// Writeback
	input  logic [dispatch_pkg::WB_WIDTH-1:0]                        wb_valid_i,
	input  dispatch_pkg::preg_idx_t [dispatch_pkg::WB_WIDTH-1:0]     wb_pdest_i,
	// Recovery sweep
	input  logic                                                     sweep_en_i,
	input  dispatch_pkg::preg_idx_t                                  sweep_idx_i
);

	// One bit per physical register
	logic [dispatch_pkg::PREG_NUM-1:0] ready_q;

	// Lookup with same-cycle writeback bypass
	always_comb begin
		for (int i = 0; i < dispatch_pkg::DECODE_WIDTH; i++) begin
			lk_src0_rdy_o[i] = ready_q[lk_src0_i[i]];
			lk_src1_rdy_o[i] = ready_q[lk_src1_i[i]];
			for (int j = 0; j < dispatch_pkg::WB_WIDTH; j++) begin
				if (wb_valid_i[j] && (wb_pdest_i[j] == lk_src0_i[i])) begin
					lk_src0_rdy_o[i] = 1'b1;
				end
				if (wb_valid_i[j] && (wb_pdest_i[j] == lk_src1_i[i])) begin
					lk_src1_rdy_o[i] = 1'b1;
				end
			end
		end
	end

	// Later assignments win: alloc clear, then wb set, then sweep set
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ready_q <= '1;
		end else begin
			for (int i = 0; i < dispatch_pkg::DECODE_WIDTH; i++) begin
				if (alloc_valid_i[i]) begin
					ready_q[alloc_pdest_i[i]] <= 1'b0;
				end
			end
			for (int j = 0; j < dispatch_pkg::WB_WIDTH; j++) begin
				if (wb_valid_i[j]) begin
					ready_q[wb_pdest_i[j]] <= 1'b1;
				end
			end
			if (sweep_en_i) begin
				ready_q[sweep_idx_i] <= 1'b1;
			end
		end
	end

	// Decode must be held off by the top while the sweep runs
	a_no_alloc_in_sweep: assert property (@(posedge clk) disable iff (!rst_n)
		sweep_en_i |-> !(|alloc_valid_i));

endmodule

// ==== design/recovery_fsm.sv ====
// Flush recovery FSM, sweeps the ready table and blocks decode until done
module recovery_fsm (
	input  logic clk,
	input  logic rst_n,
	input  logic flush_i,
	input  logic sweep_last_i,
	output logic sweep_en_o,
	output logic write_block_o,
	output logic recovering_o
);

	dispatch_pkg::rec_state_t state_q;
	dispatch_pkg::rec_state_t state_d;

	always_comb begin
		state_d = state_q;
		case (state_q)
			dispatch_pkg::RUN: begin
				if (flush_i) begin
					state_d = dispatch_pkg::SWEEP;
				end
			end
			dispatch_pkg::SWEEP: begin
				// Flush here restarts the counter, state holds
				if (!flush_i && sweep_last_i) begin
					state_d = dispatch_pkg::RESUME;
				end
			end
			dispatch_pkg::RESUME: begin
				state_d = flush_i ? dispatch_pkg::SWEEP : dispatch_pkg::RUN;
			end
			default: state_d = dispatch_pkg::RUN;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= dispatch_pkg::RUN;
		end else begin
			state_q <= state_d;
		end
	end

	// Decode stays blocked in SWEEP only
	assign sweep_en_o    = (state_q == dispatch_pkg::SWEEP);
	assign write_block_o = (state_q == dispatch_pkg::SWEEP);
	assign recovering_o  = (state_q == dispatch_pkg::SWEEP);

	// Counter sits at its last index only while a sweep runs
	a_last_in_sweep: assert property (@(posedge clk) disable iff (!rst_n)
		sweep_last_i |-> sweep_en_o);

	// A sweep that reaches RESUME ran for at least every register
	a_sweep_length: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(state_q == dispatch_pkg::RESUME)
		|-> $past(sweep_en_o, dispatch_pkg::PREG_NUM));

endmodule

// ==== design/sweep_counter.sv ====
// Sweep counter that walks every physical register index during flush recovery
module sweep_counter (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    restart_i,
	input  logic                    sweep_en_i,
	output dispatch_pkg::preg_idx_t sweep_idx_o,
	output logic                    sweep_last_o
);

	dispatch_pkg::preg_idx_t idx_q;

	// Restart beats enable so a repeated flush begins again at zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx_q <= '0;
		end else if (restart_i) begin
			idx_q <= '0;
		end else if (sweep_en_i) begin
			// Wraps to zero after the last register
			idx_q <= idx_q + dispatch_pkg::PREG_W'(1);
		end
	end

	assign sweep_idx_o = idx_q;

	// Last register of the file
	assign sweep_last_o = (idx_q == dispatch_pkg::PREG_W'(dispatch_pkg::PREG_NUM - 1));

endmodule

// ==== design/dispatch_top.sv ====
// Dispatch stage top, queue plus physical register ready table and flush recovery
module dispatch_top (
	input  logic                                                       clk,
	input  logic                                                       rst_n,
	// Decode side
	input  logic [dispatch_pkg::DECODE_WIDTH-1:0]                      wr_valid_i,
	input  dispatch_pkg::opcode_t   [dispatch_pkg::DECODE_WIDTH-1:0]   wr_opcode_i,
	input  dispatch_pkg::preg_idx_t [dispatch_pkg::DECODE_WIDTH-1:0]   wr_pdest_i,
	input  dispatch_pkg::preg_idx_t [dispatch_pkg::DECODE_WIDTH-1:0]   wr_src0_i,
	input  dispatch_pkg::preg_idx_t [dispatch_pkg::DECODE_WIDTH-1:0]   wr_src1_i,
	output logic                                                       wr_ready_o,
	// Issue side
	output logic [dispatch_pkg::DISPATCH_WIDTH-1:0]                    rd_valid_o,
	output dispatch_pkg::opcode_t   [dispatch_pkg::DISPATCH_WIDTH-1:0] rd_opcode_o,
	output dispatch_pkg::preg_idx_t [dispatch_pkg::DISPATCH_WIDTH-1:0] rd_pdest_o,
	output dispatch_pkg::preg_idx_t [dispatch_pkg::DISPATCH_WIDTH-1:0] rd_src0_o,
	output dispatch_pkg::preg_idx_t [dispatch_pkg::DISPATCH_WIDTH-1:0] rd_src1_o,
	output logic [dispatch_pkg::DISPATCH_WIDTH-1:0]                    rd_src0_rdy_o,
	output logic [dispatch_pkg::DISPATCH_WIDTH-1:0]                    rd_src1_rdy_o,
	input  logic [dispatch_pkg::DISPATCH_WIDTH-1:0]                    rd_ready_i,
	// Writeback
	input  logic [dispatch_pkg::WB_WIDTH-1:0]                          wb_valid_i,
	input  dispatch_pkg::preg_idx_t [dispatch_pkg::WB_WIDTH-1:0]       wb_pdest_i,
	// Control
	input  logic                                                       flush_i,
	output logic                                                       recovering_o
);

	logic [dispatch_pkg::DECODE_WIDTH-1:0] src0_rdy;
	logic [dispatch_pkg::DECODE_WIDTH-1:0] src1_rdy;
	logic [dispatch_pkg::DECODE_WIDTH-1:0] alloc_valid;
	logic                                  sweep_en;
	logic                                  sweep_last;
	logic                                  write_block;
	dispatch_pkg::preg_idx_t               sweep_idx;

	// Accepted decode slots allocate their destinations
	assign alloc_valid = wr_valid_i & {dispatch_pkg::DECODE_WIDTH{wr_ready_o}};

	dispatch_queue #(
		.QUEUE_DEPTH(8)
	) u_queue (
		.clk          (clk),
		.rst_n        (rst_n),
		.flush_i      (flush_i),
		.wr_valid_i   (wr_valid_i),
		.wr_opcode_i  (wr_opcode_i),
		.wr_pdest_i   (wr_pdest_i),
		.wr_src0_i    (wr_src0_i),
		.wr_src1_i    (wr_src1_i),
		.wr_src0_rdy_i(src0_rdy),
		.wr_src1_rdy_i(src1_rdy),
		.write_block_i(write_block),
		.wr_ready_o   (wr_ready_o),
		.rd_valid_o   (rd_valid_o),
		.rd_opcode_o  (rd_opcode_o),
		.rd_pdest_o   (rd_pdest_o),
		.rd_src0_o    (rd_src0_o),
		.rd_src1_o    (rd_src1_o),
		.rd_src0_rdy_o(rd_src0_rdy_o),
		.rd_src1_rdy_o(rd_src1_rdy_o),
		.rd_ready_i   (rd_ready_i),
		.wb_valid_i   (wb_valid_i),
		.wb_pdest_i   (wb_pdest_i)
	);

	preg_ready_table u_ready (
		.clk          (clk),
		.rst_n        (rst_n),
		.lk_src0_i    (wr_src0_i),
		.lk_src1_i    (wr_src1_i),
		.lk_src0_rdy_o(src0_rdy),
		.lk_src1_rdy_o(src1_rdy),
		.alloc_valid_i(alloc_valid),
		.alloc_pdest_i(wr_pdest_i),
		.wb_valid_i   (wb_valid_i),
		.wb_pdest_i   (wb_pdest_i),
		.sweep_en_i   (sweep_en),
		.sweep_idx_i  (sweep_idx)
	);

	recovery_fsm u_recovery (
		.clk          (clk),
		.rst_n        (rst_n),
		.flush_i      (flush_i),
		.sweep_last_i (sweep_last),
		.sweep_en_o   (sweep_en),
		.write_block_o(write_block),
		.recovering_o (recovering_o)
	);

	// Every flush restarts the walk at register zero
	sweep_counter u_sweep (
		.clk         (clk),
		.rst_n       (rst_n),
		.restart_i   (flush_i),
		.sweep_en_i  (sweep_en),
		.sweep_idx_o (sweep_idx),
		.sweep_last_o(sweep_last)
	);

endmodule

// ==== test/tb_dispatch_top.sv ====
// Dispatch stage testbench, random and directed traffic checked against a cycle model
module tb_dispatch_top;

	timeunit 1ns;
	timeprecision 1ps;

	// Matches the depth set inside dispatch_top
	localparam int QUEUE_DEPTH  = 8;
	localparam int RESET_CYCLES = 5;
	// Cycles per test, the timeout is their sum plus a margin
	localparam int T1_CYCLES    = 120;
	localparam int T2_CYCLES    = 24;
	localparam int T3_CYCLES    = 80;
	localparam int T4_CYCLES    = 80;
	localparam int T5_CYCLES    = 50;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
		+ T4_CYCLES + T5_CYCLES + 200;

	logic clk;
	logic rst_n;
	logic [dispatch_pkg::DECODE_WIDTH-1:0]                      wr_valid_i;
	dispatch_pkg::opcode_t   [dispatch_pkg::DECODE_WIDTH-1:0]   wr_opcode_i;
	dispatch_pkg::preg_idx_t [dispatch_pkg::DECODE_WIDTH-1:0]   wr_pdest_i;
	dispatch_pkg::preg_idx_t [dispatch_pkg::DECODE_WIDTH-1:0]   wr_src0_i;
	dispatch_pkg::preg_idx_t [dispatch_pkg::DECODE_WIDTH-1:0]   wr_src1_i;
	logic                                                       wr_ready_o;
	logic [dispatch_pkg::DISPATCH_WIDTH-1:0]                    rd_valid_o;
	dispatch_pkg::opcode_t   [dispatch_pkg::DISPATCH_WIDTH-1:0] rd_opcode_o;
	dispatch_pkg::preg_idx_t [dispatch_pkg::DISPATCH_WIDTH-1:0] rd_pdest_o;
	dispatch_pkg::preg_idx_t [dispatch_pkg::DISPATCH_WIDTH-1:0] rd_src0_o;
	dispatch_pkg::preg_idx_t [dispatch_pkg::DISPATCH_WIDTH-1:0] rd_src1_o;
	logic [dispatch_pkg::DISPATCH_WIDTH-1:0]                    rd_src0_rdy_o;
	logic [dispatch_pkg::DISPATCH_WIDTH-1:0]                    rd_src1_rdy_o;
	logic [dispatch_pkg::DISPATCH_WIDTH-1:0]                    rd_ready_i;
	logic [dispatch_pkg::WB_WIDTH-1:0]                          wb_valid_i;
	dispatch_pkg::preg_idx_t [dispatch_pkg::WB_WIDTH-1:0]       wb_pdest_i;
	logic                                                       flush_i;
	logic                                                       recovering_o;

	// Model state, entry is {opcode, pdest, src0, src1, src0 ready, src1 ready}
	logic [24:0] m_q[$];
	logic [31:0] m_ready;
	int          m_sweep_left;

	integer seed;
	string  cur_test;
	int     cycle_cnt;
	int     n_checks;
	int     n_errors;
	int     n_tests;
	int     n_failed;
	int     err_base;
	int     rec_cycles;

	dispatch_top dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ========================================
	// Reference model
	// ========================================

	function automatic logic wb_hit(input dispatch_pkg::preg_idx_t idx);
		logic hit;
		hit = 1'b0;
		for (int j = 0; j < dispatch_pkg::WB_WIDTH; j++) begin
			if (wb_valid_i[j] && (wb_pdest_i[j] == idx)) begin
				hit = 1'b1;
			end
		end
		return hit;
	endfunction

	// Room for a full group and no sweep running
	function automatic logic ref_wr_ready();
		return (m_q.size() <= QUEUE_DEPTH - dispatch_pkg::DECODE_WIDTH) && (m_sweep_left == 0);
	endfunction

	function automatic void ref_reset();
		m_q.delete();
		m_ready = '1;
		m_sweep_left = 0;
	endfunction

	// Advances the model across one rising edge with the inputs now applied
	function automatic void ref_step();
		logic [31:0] next_rdy;
		logic [24:0] ent;
		logic        accept;
		int          n_rd;
		accept = ref_wr_ready();
		next_rdy = m_ready;
		n_rd = 0;
		if (flush_i) begin
			m_q.delete();
		end else begin
			// Wakeup of sources already waiting
			for (int i = 0; i < m_q.size(); i++) begin
				ent = m_q[i];
				if (wb_hit(ent[11:7])) begin
					ent[1] = 1'b1;
				end
				if (wb_hit(ent[6:2])) begin
					ent[0] = 1'b1;
				end
				m_q[i] = ent;
			end
			for (int i = 0; i < dispatch_pkg::DISPATCH_WIDTH; i++) begin
				if (rd_ready_i[i] && (m_q.size() > i)) begin
					n_rd++;
				end
			end
			for (int i = 0; i < n_rd; i++) begin
				ent = m_q.pop_front();
			end
			// New entries see the table before this edge plus the bypass
			for (int i = 0; i < dispatch_pkg::DECODE_WIDTH; i++) begin
				if (accept && wr_valid_i[i]) begin
					ent = {wr_opcode_i[i], wr_pdest_i[i], wr_src0_i[i], wr_src1_i[i],
						m_ready[wr_src0_i[i]] | wb_hit(wr_src0_i[i]),
						m_ready[wr_src1_i[i]] | wb_hit(wr_src1_i[i])};
					m_q.push_back(ent);
				end
			end
		end
		// Allocation clears, writeback wins over it, sweep sets one register
		for (int i = 0; i < dispatch_pkg::DECODE_WIDTH; i++) begin
			if (accept && wr_valid_i[i]) begin
				next_rdy[wr_pdest_i[i]] = 1'b0;
			end
		end
		for (int j = 0; j < dispatch_pkg::WB_WIDTH; j++) begin
			if (wb_valid_i[j]) begin
				next_rdy[wb_pdest_i[j]] = 1'b1;
			end
		end
		if (m_sweep_left > 0) begin
			next_rdy[5'(int'(dispatch_pkg::PREG_NUM) - m_sweep_left)] = 1'b1;
		end
		m_ready = next_rdy;
		if (flush_i) begin
			m_sweep_left = int'(dispatch_pkg::PREG_NUM);
		end else if (m_sweep_left > 0) begin
			m_sweep_left--;
		end
	endfunction

	// ========================================
	// Comparison
	// ========================================

	task automatic report_mismatch(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		n_errors++;
		$display("error %s %s expected %h actual %h", cur_test, what, exp, act);
	endtask

	task automatic check_outputs();
		logic [24:0] act;
		logic [1:0]  exp_valid;
		exp_valid = {m_q.size() > 1, m_q.size() > 0};
		n_checks += 3;
		if (wr_ready_o !== ref_wr_ready()) begin
			report_mismatch("wr_ready_o", 32'(ref_wr_ready()), 32'(wr_ready_o));
		end
		if (recovering_o !== (m_sweep_left > 0)) begin
			report_mismatch("recovering_o", 32'(m_sweep_left > 0), 32'(recovering_o));
		end
		if (rd_valid_o !== exp_valid) begin
			report_mismatch("rd_valid_o", 32'(exp_valid), 32'(rd_valid_o));
		end
		// Payload only matters on valid slots
		for (int i = 0; i < dispatch_pkg::DISPATCH_WIDTH; i++) begin
			if (i < m_q.size()) begin
				act = {rd_opcode_o[i], rd_pdest_o[i], rd_src0_o[i], rd_src1_o[i],
					rd_src0_rdy_o[i], rd_src1_rdy_o[i]};
				n_checks++;
				if (act !== m_q[i]) begin
					report_mismatch("issue entry", 32'(m_q[i]), 32'(act));
				end
			end
		end
	endtask

	// Falling edge, DUT outputs and driven inputs are both settled
	always @(negedge clk) begin
		if (rst_n !== 1'b1) begin
			ref_reset();
		end else begin
			check_outputs();
			ref_step();
		end
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT_CYCLES) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAIL");
			$finish;
		end
	end

	// ========================================
	// Stimulus
	// ========================================

	// rd_mode 0 holds issue off, 1 random in-order ready, 2 always ready
	task automatic drive_random(input int cycles, input int rd_mode, input logic wb_on,
		input logic [4:0] mask);
		logic [31:0] r;
		logic [31:0] rs;
		for (int c = 0; c < cycles; c++) begin
			@(posedge clk);
			r = $random(seed);
			// Packed groups only, 00, 01 or 11
			wr_valid_i <= (r[1:0] == 2'd0) ? 2'b00 : ((r[1:0] == 2'd1) ? 2'b01 : 2'b11);
			for (int i = 0; i < dispatch_pkg::DECODE_WIDTH; i++) begin
				rs = $random(seed);
				wr_opcode_i[i] <= rs[7:0];
				wr_pdest_i[i]  <= rs[12:8] & mask;
				wr_src0_i[i]   <= rs[17:13] & mask;
				wr_src1_i[i]   <= rs[22:18] & mask;
			end
			for (int j = 0; j < dispatch_pkg::WB_WIDTH; j++) begin
				rs = $random(seed);
				wb_pdest_i[j] <= rs[4:0] & mask;
				wb_valid_i[j] <= wb_on && rs[5];
			end
			if (rd_mode == 0) begin
				rd_ready_i <= 2'b00;
			end else if (rd_mode == 2) begin
				rd_ready_i <= 2'b11;
			end else begin
				rd_ready_i <= (r[3:2] == 2'd0) ? 2'b00 : ((r[3:2] == 2'd1) ? 2'b01 : 2'b11);
			end
		end
	endtask

	// Groups whose sources cover every register once
	task automatic drive_cover();
		for (int g = 0; g < 8; g++) begin
			@(posedge clk);
			wr_valid_i     <= 2'b11;
			rd_ready_i     <= 2'b11;
			wb_valid_i     <= 2'b00;
			wr_opcode_i[0] <= 8'(g);
			wr_opcode_i[1] <= 8'(g + 8);
			wr_pdest_i[0]  <= 5'(4 * g);
			wr_pdest_i[1]  <= 5'(4 * g + 1);
			wr_src0_i[0]   <= 5'(4 * g);
			wr_src1_i[0]   <= 5'(4 * g + 1);
			wr_src0_i[1]   <= 5'(4 * g + 2);
			wr_src1_i[1]   <= 5'(4 * g + 3);
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		err_base = n_errors;
	endtask

	// Idle inputs and wait for the last response before reporting
	task automatic finish_test();
		@(posedge clk);
		wr_valid_i <= 2'b00;
		wb_valid_i <= 2'b00;
		rd_ready_i <= 2'b11;
		// Next rising edge comes after the compare of the last entries
		@(posedge clk);
		n_tests++;
		if (n_errors != err_base) begin
			n_failed++;
			$display("test %s: %0d errors", cur_test, n_errors - err_base);
		end else begin
			$display("test %s: passed", cur_test);
		end
	endtask

	initial begin
		seed = 32'heccb_a0fb;
		cycle_cnt = 0;
		n_checks = 0;
		n_errors = 0;
		n_tests = 0;
		n_failed = 0;
		cur_test = "reset";
		rst_n       <= 1'b0;
		flush_i     <= 1'b0;
		wr_valid_i  <= '0;
		wr_opcode_i <= '0;
		wr_pdest_i  <= '0;
		wr_src0_i   <= '0;
		wr_src1_i   <= '0;
		rd_ready_i  <= '0;
		wb_valid_i  <= '0;
		wb_pdest_i  <= '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		start_test("in_order_dispatch");
		drive_random(T1_CYCLES, 1, 1'b0, 5'h1f);
		finish_test();

		// Fill with issue stalled, then drain
		start_test("back_pressure");
		drive_random(T2_CYCLES / 2, 0, 1'b0, 5'h1f);
		drive_random(T2_CYCLES / 2, 2, 1'b0, 5'h1f);
		finish_test();

		start_test("wakeup");
		drive_random(T3_CYCLES, 1, 1'b1, 5'h0f);
		finish_test();

		// Narrow index range makes allocation and writeback collide often
		start_test("allocation");
		drive_random(T4_CYCLES, 1, 1'b1, 5'h07);
		finish_test();

		start_test("flush_recovery");
		drive_random(6, 0, 1'b0, 5'h1f);
		@(posedge clk);
		flush_i    <= 1'b1;
		wr_valid_i <= 2'b00;
		wb_valid_i <= 2'b00;
		@(posedge clk);
		flush_i <= 1'b0;
		@(negedge clk);
		rec_cycles = 0;
		// Bounded wait for the sweep to end
		while (recovering_o && (rec_cycles < 64)) begin
			rec_cycles++;
			@(negedge clk);
		end
		n_checks++;
		if (rec_cycles != int'(dispatch_pkg::PREG_NUM)) begin
			report_mismatch("recovery cycles", 32'(dispatch_pkg::PREG_NUM), 32'(rec_cycles));
		end
		drive_cover();
		finish_test();

		$display("tests %0d, failed tests %0d, checks %0d, errors %0d",
			n_tests, n_failed, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== all.f ====
design/dispatch_pkg.sv
design/dispatch_queue.sv
design/preg_ready_table.sv
design/recovery_fsm.sv
design/sweep_counter.sv
design/dispatch_top.sv
test/tb_dispatch_top.sv

// ==== run.sh ====
#!/bin/sh
# Compile the dispatch stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_dispatch_top -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "verilator compile failed with status $status"
	exit 1
fi

./obj_dir/Vtb_dispatch_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $LOG"
	exit 1
fi
